// ==== source/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // instruction address
    typedef logic [31:0] pc_t;

    // register number
    // r0 is never a hazard source
    typedef logic [4:0] reg_addr_t;

    // extra execute cycles of a long ALU op
    typedef logic [3:0] alu_cnt_t;

    // multi-cycle sequencer in execute
    typedef enum logic {
        idle,
        busy
    } stage_state_t;

    // boot address
    localparam pc_t reset_pc_default = 32'h0000_0000;

    // trap handler entry
    localparam pc_t except_vector_default = 32'h0000_0180;

endpackage

`default_nettype wire

// ==== source/hazard.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard
    import pipe_pkg::*;
(
    input  wire            i_stall,
    input  wire            d_stall,
    input  wire            d_read_rs,
    input  wire            d_read_rt,
    input  wire reg_addr_t d_rs,
    input  wire reg_addr_t d_rt,
    input  wire            e_mem_to_reg,
    input  wire reg_addr_t e_waddr,
    input  wire            e_branch_taken,
    input  wire            e_alu_stall,
    input  wire            m_except,
    output logic           pc_en,
    output logic           f_ena,
    output logic           d_ena,
    output logic           e_ena,
    output logic           m_ena,
    output logic           w_ena,
    output logic           d_flush,
    output logic           e_flush,
    output logic           m_flush
);

    logic lw_stall;
    logic long_stall;
    logic is_flush;
    logic fd_wait_stall;
    logic fd_conflict_stall;
    logic redirect_hold;
    logic m_except_ok;
    logic br_ok;

    // load in E feeds a source read in D
    assign lw_stall = e_mem_to_reg && (e_waddr != '0) &&
                      ((d_read_rs && (d_rs == e_waddr)) || (d_read_rt && (d_rt == e_waddr)));

    // stalls from behind D
    assign long_stall = e_alu_stall | d_stall;

    // anything that moves the PC off the sequential path
    assign is_flush = m_except | e_branch_taken;

    // redirect pending, fetch still waiting
    assign fd_wait_stall = i_stall & is_flush;
    // redirect pending, back end held
    assign fd_conflict_stall = long_stall & is_flush;
    assign redirect_hold = fd_wait_stall | fd_conflict_stall;

    // redirects that actually fire this cycle
    assign m_except_ok = m_except & ~redirect_hold;
    assign br_ok = e_branch_taken & ~redirect_hold;

    assign pc_en = ~redirect_hold;

    // sequential fetch only when D takes the token
    assign f_ena = ~(i_stall | lw_stall | long_stall);
    assign d_ena = ~(lw_stall | long_stall | fd_wait_stall);
    assign e_ena = ~(long_stall | fd_wait_stall);
    assign m_ena = ~(long_stall | fd_wait_stall);
    // W also opens so the trapping token leaves M
    assign w_ena = ~(long_stall | fd_wait_stall) | m_except_ok;

    assign d_flush = m_except_ok | br_ok;
    // load-use bubble goes into E while D holds
    assign e_flush = m_except_ok | br_ok | (lw_stall & e_ena);
    assign m_flush = m_except_ok;

endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
    import pipe_pkg::*;
#(
    parameter pc_t reset_pc      = reset_pc_default,
    parameter pc_t except_vector = except_vector_default
) (
    input  wire            clk,
    input  wire            arst_n,
    input  wire            pc_en,
    input  wire            f_ena,
    input  wire            e_branch_taken,
    input  wire pc_t       br_target,
    input  wire            m_except_ok,
    input  wire            i_stall,
    output pc_t            imem_addr,
    input  wire reg_addr_t imem_rs,
    input  wire reg_addr_t imem_rt,
    input  wire            imem_read_rs,
    input  wire            imem_read_rt,
    input  wire reg_addr_t imem_waddr,
    input  wire            imem_mem_to_reg,
    input  wire            imem_br_taken,
    input  wire pc_t       imem_br_target,
    input  wire alu_cnt_t  imem_alu_cnt,
    input  wire            imem_trap,
    output logic           f_valid,
    output pc_t            f_pc,
    output reg_addr_t      f_rs,
    output reg_addr_t      f_rt,
    output logic           f_read_rs,
    output logic           f_read_rt,
    output reg_addr_t      f_waddr,
    output logic           f_mem_to_reg,
    output logic           f_br_taken,
    output pc_t            f_br_target,
    output alu_cnt_t       f_alu_cnt,
    output logic           f_trap
);

    pc_t pc;

    // exception beats branch, both wait for pc_en
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else if (pc_en && m_except_ok) begin
            pc <= except_vector;
        end else if (pc_en && e_branch_taken) begin
            pc <= br_target;
        end else if (f_ena) begin
            pc <= pc + 32'd4;
        end
    end

    assign imem_addr = pc;

    // memory answers in the same cycle unless stalled
    assign f_valid      = ~i_stall;
    assign f_pc         = pc;
    assign f_rs         = imem_rs;
    assign f_rt         = imem_rt;
    assign f_read_rs    = imem_read_rs;
    assign f_read_rt    = imem_read_rt;
    assign f_waddr      = imem_waddr;
    assign f_mem_to_reg = imem_mem_to_reg;
    assign f_br_taken   = imem_br_taken;
    assign f_br_target  = imem_br_target;
    assign f_alu_cnt    = imem_alu_cnt;
    assign f_trap       = imem_trap;

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage
    import pipe_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            d_ena,
    input  wire            d_flush,
    input  wire            f_valid,
    input  wire pc_t       f_pc,
    input  wire reg_addr_t f_rs,
    input  wire reg_addr_t f_rt,
    input  wire            f_read_rs,
    input  wire            f_read_rt,
    input  wire reg_addr_t f_waddr,
    input  wire            f_mem_to_reg,
    input  wire            f_br_taken,
    input  wire pc_t       f_br_target,
    input  wire alu_cnt_t  f_alu_cnt,
    input  wire            f_trap,
    output logic           d_valid,
    output pc_t            d_pc,
    output reg_addr_t      d_rs,
    output reg_addr_t      d_rt,
    output logic           d_read_rs,
    output logic           d_read_rt,
    output reg_addr_t      d_waddr,
    output logic           d_mem_to_reg,
    output logic           d_br_taken,
    output pc_t            d_br_target,
    output alu_cnt_t       d_alu_cnt,
    output logic           d_trap
);

    // read flags only count for a live token
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            d_valid   <= 1'b0;
            d_read_rs <= 1'b0;
            d_read_rt <= 1'b0;
        end else if (d_flush) begin
            d_valid   <= 1'b0;
            d_read_rs <= 1'b0;
            d_read_rt <= 1'b0;
        end else if (d_ena) begin
            d_valid   <= f_valid;
            d_read_rs <= f_valid & f_read_rs;
            d_read_rt <= f_valid & f_read_rt;
        end
    end

    always_ff @(posedge clk) begin
        if (d_ena) begin
            d_pc         <= f_pc;
            d_rs         <= f_rs;
            d_rt         <= f_rt;
            d_waddr      <= f_waddr;
            d_mem_to_reg <= f_mem_to_reg;
            d_br_taken   <= f_br_taken;
            d_br_target  <= f_br_target;
            d_alu_cnt    <= f_alu_cnt;
            d_trap       <= f_trap;
        end
    end

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_stage
    import pipe_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            e_ena,
    input  wire            e_flush,
    input  wire            d_valid,
    input  wire pc_t       d_pc,
    input  wire reg_addr_t d_waddr,
    input  wire            d_mem_to_reg,
    input  wire            d_br_taken,
    input  wire pc_t       d_br_target,
    input  wire alu_cnt_t  d_alu_cnt,
    input  wire            d_trap,
    output logic           e_valid,
    output pc_t            e_pc,
    output reg_addr_t      e_waddr,
    output logic           e_mem_to_reg,
    output logic           e_trap,
    output logic           e_alu_stall,
    output logic           e_branch_taken,
    output pc_t            br_target
);

    logic         br_taken;
    alu_cnt_t     alu_cnt;
    stage_state_t state;
    alu_cnt_t     cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            e_valid      <= 1'b0;
            e_mem_to_reg <= 1'b0;
        end else if (e_flush) begin
            e_valid      <= 1'b0;
            e_mem_to_reg <= 1'b0;
        end else if (e_ena) begin
            e_valid      <= d_valid;
            e_mem_to_reg <= d_valid & d_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (e_ena) begin
            e_pc      <= d_pc;
            e_waddr   <= d_waddr;
            e_trap    <= d_trap;
            br_taken  <= d_br_taken;
            br_target <= d_br_target;
            alu_cnt   <= d_alu_cnt;
        end
    end

    // first stall cycle comes from idle, the rest from the counter
    always_comb begin
        if (state == idle) begin
            e_alu_stall = e_valid && (alu_cnt != '0);
        end else begin
            e_alu_stall = (cnt != '0);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
            cnt   <= '0;
        end else if (e_flush) begin
            state <= idle;
            cnt   <= '0;
        end else begin
            case (state)
                idle: begin
                    if (e_valid && (alu_cnt != '0)) begin
                        state <= busy;
                        cnt   <= alu_cnt - 1'b1;
                    end
                end
                busy: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else if (e_ena) begin
                        // token moves on, ready for the next one
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // resolve only once the long op is done
    assign e_branch_taken = e_valid & br_taken & ~e_alu_stall;

endmodule

`default_nettype wire

// ==== source/memory_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_stage
    import pipe_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            m_ena,
    input  wire            m_flush,
    input  wire            e_valid,
    input  wire pc_t       e_pc,
    input  wire reg_addr_t e_waddr,
    input  wire            e_trap,
    output logic           m_valid,
    output pc_t            m_pc,
    output reg_addr_t      m_waddr,
    output logic           m_trap,
    output logic           m_first,
    output logic           m_except
);

    // set by a taken trap until the handler's first token shows up
    logic handler_pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid         <= 1'b0;
            m_first         <= 1'b0;
            handler_pending <= 1'b0;
        end else if (m_flush) begin
            m_valid <= 1'b0;
            m_first <= 1'b0;
            if (m_except) begin
                handler_pending <= 1'b1;
            end
        end else if (m_ena) begin
            m_valid <= e_valid;
            m_first <= e_valid & handler_pending;
            if (e_valid) begin
                handler_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (m_ena) begin
            m_pc    <= e_pc;
            m_waddr <= e_waddr;
            m_trap  <= e_trap;
        end
    end

    assign m_except = m_valid & m_trap;

endmodule

`default_nettype wire

// ==== source/writeback_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module writeback_stage
    import pipe_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire            w_ena,
    input  wire            m_valid,
    input  wire pc_t       m_pc,
    input  wire reg_addr_t m_waddr,
    input  wire            m_trap,
    input  wire            m_first,
    output logic           retire_valid,
    output pc_t            retire_pc,
    output reg_addr_t      retire_waddr,
    output logic           retire_except
);

    logic w_valid;
    logic w_first;

    // trapping token is dropped here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w_valid <= 1'b0;
            w_first <= 1'b0;
        end else if (w_ena) begin
            w_valid <= m_valid & ~m_trap;
            w_first <= m_first;
        end else begin
            // bubble
            w_valid <= 1'b0;
            w_first <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (w_ena) begin
            retire_pc    <= m_pc;
            retire_waddr <= m_waddr;
        end
    end

    assign retire_valid  = w_valid;
    assign retire_except = w_valid & w_first;

endmodule

`default_nettype wire

// ==== source/pipe_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_top
    import pipe_pkg::*;
#(
    parameter pc_t reset_pc      = reset_pc_default,
    parameter pc_t except_vector = except_vector_default
) (
    input  wire            clk,
    input  wire            arst_n,
    output pc_t            imem_addr,
    input  wire reg_addr_t imem_rs,
    input  wire reg_addr_t imem_rt,
    input  wire            imem_read_rs,
    input  wire            imem_read_rt,
    input  wire reg_addr_t imem_waddr,
    input  wire            imem_mem_to_reg,
    input  wire            imem_br_taken,
    input  wire pc_t       imem_br_target,
    input  wire alu_cnt_t  imem_alu_cnt,
    input  wire            imem_trap,
    input  wire            i_stall,
    input  wire            d_stall,
    output logic           retire_valid,
    output pc_t            retire_pc,
    output reg_addr_t      retire_waddr,
    output logic           retire_except
);

    logic pc_en, f_ena, d_ena, e_ena, m_ena, w_ena;
    logic d_flush, e_flush, m_flush;

    logic      f_valid, f_read_rs, f_read_rt, f_mem_to_reg, f_br_taken, f_trap;
    pc_t       f_pc, f_br_target;
    reg_addr_t f_rs, f_rt, f_waddr;
    alu_cnt_t  f_alu_cnt;

    logic      d_valid, d_read_rs, d_read_rt, d_mem_to_reg, d_br_taken, d_trap;
    pc_t       d_pc, d_br_target;
    reg_addr_t d_rs, d_rt, d_waddr;
    alu_cnt_t  d_alu_cnt;

    logic      e_valid, e_mem_to_reg, e_trap, e_alu_stall, e_branch_taken;
    pc_t       e_pc, br_target;
    reg_addr_t e_waddr;

    logic      m_valid, m_trap, m_first, m_except;
    pc_t       m_pc;
    reg_addr_t m_waddr;

    hazard u_hazard (
        .i_stall(i_stall), .d_stall(d_stall),
        .d_read_rs(d_read_rs), .d_read_rt(d_read_rt), .d_rs(d_rs), .d_rt(d_rt),
        .e_mem_to_reg(e_mem_to_reg), .e_waddr(e_waddr),
        .e_branch_taken(e_branch_taken), .e_alu_stall(e_alu_stall), .m_except(m_except),
        .pc_en(pc_en), .f_ena(f_ena), .d_ena(d_ena), .e_ena(e_ena),
        .m_ena(m_ena), .w_ena(w_ena),
        .d_flush(d_flush), .e_flush(e_flush), .m_flush(m_flush)
    );

    fetch_stage #(
        .reset_pc(reset_pc),
        .except_vector(except_vector)
    ) u_fetch (
        .clk(clk), .arst_n(arst_n), .pc_en(pc_en), .f_ena(f_ena),
        .e_branch_taken(e_branch_taken), .br_target(br_target),
        .m_except_ok(m_except), .i_stall(i_stall), .imem_addr(imem_addr),
        .imem_rs(imem_rs), .imem_rt(imem_rt),
        .imem_read_rs(imem_read_rs), .imem_read_rt(imem_read_rt),
        .imem_waddr(imem_waddr), .imem_mem_to_reg(imem_mem_to_reg),
        .imem_br_taken(imem_br_taken), .imem_br_target(imem_br_target),
        .imem_alu_cnt(imem_alu_cnt), .imem_trap(imem_trap),
        .f_valid(f_valid), .f_pc(f_pc), .f_rs(f_rs), .f_rt(f_rt),
        .f_read_rs(f_read_rs), .f_read_rt(f_read_rt), .f_waddr(f_waddr),
        .f_mem_to_reg(f_mem_to_reg), .f_br_taken(f_br_taken),
        .f_br_target(f_br_target), .f_alu_cnt(f_alu_cnt), .f_trap(f_trap)
    );

    decode_stage u_decode (
        .clk(clk), .arst_n(arst_n), .d_ena(d_ena), .d_flush(d_flush),
        .f_valid(f_valid), .f_pc(f_pc), .f_rs(f_rs), .f_rt(f_rt),
        .f_read_rs(f_read_rs), .f_read_rt(f_read_rt), .f_waddr(f_waddr),
        .f_mem_to_reg(f_mem_to_reg), .f_br_taken(f_br_taken),
        .f_br_target(f_br_target), .f_alu_cnt(f_alu_cnt), .f_trap(f_trap),
        .d_valid(d_valid), .d_pc(d_pc), .d_rs(d_rs), .d_rt(d_rt),
        .d_read_rs(d_read_rs), .d_read_rt(d_read_rt), .d_waddr(d_waddr),
        .d_mem_to_reg(d_mem_to_reg), .d_br_taken(d_br_taken),
        .d_br_target(d_br_target), .d_alu_cnt(d_alu_cnt), .d_trap(d_trap)
    );

    execute_stage u_execute (
        .clk(clk), .arst_n(arst_n), .e_ena(e_ena), .e_flush(e_flush),
        .d_valid(d_valid), .d_pc(d_pc), .d_waddr(d_waddr),
        .d_mem_to_reg(d_mem_to_reg), .d_br_taken(d_br_taken),
        .d_br_target(d_br_target), .d_alu_cnt(d_alu_cnt), .d_trap(d_trap),
        .e_valid(e_valid), .e_pc(e_pc), .e_waddr(e_waddr),
        .e_mem_to_reg(e_mem_to_reg), .e_trap(e_trap), .e_alu_stall(e_alu_stall),
        .e_branch_taken(e_branch_taken), .br_target(br_target)
    );

    memory_stage u_memory (
        .clk(clk), .arst_n(arst_n), .m_ena(m_ena), .m_flush(m_flush),
        .e_valid(e_valid), .e_pc(e_pc), .e_waddr(e_waddr), .e_trap(e_trap),
        .m_valid(m_valid), .m_pc(m_pc), .m_waddr(m_waddr), .m_trap(m_trap),
        .m_first(m_first), .m_except(m_except)
    );

    writeback_stage u_writeback (
        .clk(clk), .arst_n(arst_n), .w_ena(w_ena),
        .m_valid(m_valid), .m_pc(m_pc), .m_waddr(m_waddr),
        .m_trap(m_trap), .m_first(m_first),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_waddr(retire_waddr), .retire_except(retire_except)
    );

endmodule

`default_nettype wire

// ==== bench/pipe_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_assert
    import pipe_pkg::*;
(
    input wire      clk,
    input wire      arst_n,
    input wire      i_stall,
    input wire      retire_valid,
    input wire pc_t retire_pc,
    input wire      d_flush,
    input wire      e_branch_taken,
    input wire      m_except
);

    // assertion failures so far
    int fail_count = 0;

    // nothing retires while reset is held
    reset_quiet: assert property (@(posedge clk) !arst_n |-> !retire_valid)
        else begin
            fail_count++;
            $error("retire_valid high during reset");
        end

    // same pc never retires twice in a row
    no_repeat: assert property (@(posedge clk) disable iff (!arst_n)
        (retire_valid && $past(retire_valid)) |-> (retire_pc != $past(retire_pc)))
        else begin
            fail_count++;
            $error("retire_pc %h retired on two back-to-back cycles", retire_pc);
        end

    // D is only flushed by a branch or a trap and never while fetch waits
    flush_source: assert property (@(posedge clk) disable iff (!arst_n)
        d_flush |-> ((e_branch_taken || m_except) && !i_stall))
        else begin
            fail_count++;
            $error("d_flush without a redirect source or while fetch waits");
        end

endmodule

bind pipe_top pipe_assert u_chk (
    .clk(clk),
    .arst_n(arst_n),
    .i_stall(i_stall),
    .retire_valid(retire_valid),
    .retire_pc(retire_pc),
    .d_flush(d_flush),
    .e_branch_taken(e_branch_taken),
    .m_except(m_except)
);

`default_nettype wire

// ==== bench/pipe_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_tb
    import pipe_pkg::*;
();

    localparam pc_t boot_pc = 32'h0000_0080;
    localparam pc_t vec_pc  = 32'h0000_0140;

    typedef struct packed {
        reg_addr_t rs;
        reg_addr_t rt;
        logic      read_rs;
        logic      read_rt;
        reg_addr_t waddr;
        logic      load;
        logic      br;
        pc_t       target;
        alu_cnt_t  cnt;
        logic      trap;
    } tok_t;

    logic      clk;
    logic      arst_n;
    logic      i_stall;
    logic      d_stall;
    pc_t       imem_addr;
    tok_t      cur_tok;
    logic      retire_valid;
    pc_t       retire_pc;
    reg_addr_t retire_waddr;
    logic      retire_except;

    // program memory with one token per word
    tok_t prog [0:127];

    pc_t       exp_pc [$];
    logic      exp_exc [$];
    reg_addr_t exp_wa [$];
    int        exp_gap [$];
    pc_t       got_pc [$];
    logic      got_exc [$];
    reg_addr_t got_wa [$];
    int        got_cyc [$];

    int          cyc;
    logic        rand_on;
    logic [31:0] lfsr;
    logic        b0;
    logic        b1;
    logic        b2;
    string       test_name;
    int          total_errs;
    int          tests_run;
    int          tests_failed;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // fetch answers in the same cycle
    assign cur_tok = prog[imem_addr[8:2]];

    pipe_top #(
        .reset_pc(boot_pc),
        .except_vector(vec_pc)
    ) uut (
        .clk(clk), .arst_n(arst_n), .imem_addr(imem_addr),
        .imem_rs(cur_tok.rs), .imem_rt(cur_tok.rt),
        .imem_read_rs(cur_tok.read_rs), .imem_read_rt(cur_tok.read_rt),
        .imem_waddr(cur_tok.waddr), .imem_mem_to_reg(cur_tok.load),
        .imem_br_taken(cur_tok.br), .imem_br_target(cur_tok.target),
        .imem_alu_cnt(cur_tok.cnt), .imem_trap(cur_tok.trap),
        .i_stall(i_stall), .d_stall(d_stall),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_waddr(retire_waddr), .retire_except(retire_except)
    );

    // edges since reset release
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    always @(negedge clk) begin
        if (arst_n && retire_valid) begin
            got_pc.push_back(retire_pc);
            got_exc.push_back(retire_except);
            got_wa.push_back(retire_waddr);
            got_cyc.push_back(cyc);
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    // i_stall about 1 in 4 and d_stall about 1 in 8
    always @(posedge clk) begin
        #5;
        if (rand_on) begin
            take_bit(b0);
            take_bit(b1);
            i_stall = b0 & b1;
            take_bit(b0);
            take_bit(b1);
            take_bit(b2);
            d_stall = b0 & b1 & b2;
        end else begin
            i_stall = 1'b0;
            d_stall = 1'b0;
        end
    end

    function automatic reg_addr_t fold_addr(input pc_t a);
        fold_addr = a[4:0] ^ a[9:5] ^ a[14:10] ^ a[19:15] ^ a[24:20] ^ a[29:25] ^
                    {3'b000, a[31:30]};
    endfunction

    // plain tokens with no reads and a waddr folded from the address
    task automatic clear_prog();
        pc_t a;
        for (int i = 0; i < 128; i++) begin
            a = {23'd0, 7'(i), 2'b00};
            prog[i] = '0;
            prog[i].waddr = fold_addr(a);
        end
    endtask

    task automatic put_load(input pc_t a, input reg_addr_t rd);
        prog[a[8:2]].load = 1'b1;
        prog[a[8:2]].waddr = rd;
    endtask

    task automatic put_use(input pc_t a, input reg_addr_t rs, input reg_addr_t rt);
        prog[a[8:2]].read_rs = 1'b1;
        prog[a[8:2]].rs = rs;
        prog[a[8:2]].read_rt = 1'b1;
        prog[a[8:2]].rt = rt;
    endtask

    task automatic put_branch(input pc_t a, input pc_t target);
        prog[a[8:2]].br = 1'b1;
        prog[a[8:2]].target = target;
    endtask

    task automatic put_alu(input pc_t a, input alu_cnt_t cnt);
        prog[a[8:2]].cnt = cnt;
    endtask

    task automatic put_trap(input pc_t a);
        prog[a[8:2]].trap = 1'b1;
    endtask

    function automatic logic load_use(input tok_t older, input tok_t younger);
        load_use = older.load && (older.waddr != '0) &&
                   ((younger.read_rs && (younger.rs == older.waddr)) ||
                    (younger.read_rt && (younger.rt == older.waddr)));
    endfunction

    // walk the program in order with the spacing seen when nothing stalls
    task automatic build_expected(input int n);
        pc_t  pc;
        logic pend;
        tok_t cur;
        tok_t prev;
        int   steps;
        int   gap;
        exp_pc.delete();
        exp_exc.delete();
        exp_wa.delete();
        exp_gap.delete();
        pc = boot_pc;
        pend = 1'b0;
        prev = '0;
        steps = 0;
        while (exp_pc.size() < n && steps < 1000) begin
            cur = prog[pc[8:2]];
            steps++;
            if (cur.trap) begin
                pc = vec_pc;
                pend = 1'b1;
            end else begin
                gap = 1;
                if (exp_pc.size() == 0) begin
                    gap = 4;
                end else if (load_use(prev, cur)) begin
                    gap = 2;
                end
                exp_pc.push_back(pc);
                exp_exc.push_back(pend);
                exp_wa.push_back(cur.waddr);
                exp_gap.push_back(gap);
                pend = 1'b0;
                prev = cur;
                pc = cur.br ? cur.target : pc + 32'd4;
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #5;
        arst_n = 1'b0;
        got_pc.delete();
        got_exc.delete();
        got_wa.delete();
        got_cyc.delete();
        repeat (2) @(posedge clk);
        #5;
        arst_n = 1'b1;
    endtask

    task automatic check_val(input string what, input logic [31:0] expv,
                             input logic [31:0] actv);
        assert (expv == actv) else begin
            $display("Error %s %s: expected %h, actual %h", test_name, what, expv, actv);
            total_errs++;
        end
    endtask

    task automatic run_test(input string name, input int n, input bit gaps,
                            input bit rnd, input int limit);
        int waited;
        int errs_before;
        test_name = name;
        errs_before = total_errs;
        build_expected(n);
        rand_on = rnd;
        apply_reset();
        waited = 0;
        while (got_pc.size() < n && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        rand_on = 1'b0;
        if (got_pc.size() < n) begin
            $display("%s timed out, only %0d of %0d tokens retired",
                     name, got_pc.size(), n);
            total_errs++;
        end
        for (int i = 0; i < n && i < got_pc.size(); i++) begin
            check_val("retire_pc", exp_pc[i], got_pc[i]);
            check_val("retire_except", 32'(exp_exc[i]), 32'(got_exc[i]));
            check_val("retire_waddr", 32'(exp_wa[i]), 32'(got_wa[i]));
            if (gaps && i == 0) begin
                check_val("first retire cycle", exp_gap[0], got_cyc[0]);
            end else if (gaps) begin
                check_val("retire spacing", exp_gap[i], got_cyc[i] - got_cyc[i - 1]);
            end
        end
        tests_run++;
        if (total_errs != errs_before) begin
            tests_failed++;
        end
        $display("%s: %0d retires compared, %0d errors", name, n, total_errs - errs_before);
    endtask

    initial begin
        arst_n = 1'b0;
        i_stall = 1'b0;
        d_stall = 1'b0;
        rand_on = 1'b0;
        lfsr = 32'h4690;
        total_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        clear_prog();

        run_test("straight", 8, 1'b1, 1'b0, 40);

        // r0 dependence must not stall
        clear_prog();
        put_load(boot_pc + 32'h04, 5'd5);
        put_use(boot_pc + 32'h08, 5'd5, 5'd0);
        put_load(boot_pc + 32'h0c, 5'd0);
        put_use(boot_pc + 32'h10, 5'd0, 5'd0);
        put_load(boot_pc + 32'h14, 5'd9);
        put_use(boot_pc + 32'h18, 5'd0, 5'd9);
        run_test("load_use", 9, 1'b1, 1'b0, 40);

        clear_prog();
        put_branch(boot_pc + 32'h08, 32'h40);
        run_test("branch", 6, 1'b0, 1'b0, 40);

        clear_prog();
        put_trap(boot_pc + 32'h08);
        run_test("trap", 5, 1'b0, 1'b0, 40);

        // mixed program under random stalls
        clear_prog();
        put_alu(boot_pc, 4'd3);
        put_load(boot_pc + 32'h04, 5'd7);
        put_use(boot_pc + 32'h08, 5'd7, 5'd0);
        put_alu(boot_pc + 32'h0c, 4'd2);
        put_branch(boot_pc + 32'h10, 32'h60);
        put_alu(boot_pc + 32'h10, 4'd2);
        put_alu(32'h60, 4'd1);
        put_load(32'h64, 5'd3);
        put_trap(32'h68);
        put_alu(vec_pc, 4'd2);
        put_use(vec_pc + 32'd4, 5'd3, 5'd3);
        run_test("random", 10, 1'b0, 1'b1, 400);

        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, total_errs, uut.u_chk.fail_count);
        if (total_errs == 0 && uut.u_chk.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
source/pipe_pkg.sv
source/hazard.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/writeback_stage.sv
source/pipe_top.sv
bench/pipe_assert.sv
bench/pipe_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module pipe_tb \
    -f build.f -Mdir obj_dir -o pipe_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/pipe_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
